// ==== Bender.yml ====
package:
  name: cpu_checker

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/char_pkg.sv
      - hdl/record_pkg.sv
      - hdl/char_classifier.sv
      - hdl/record_parser.sv
      - hdl/record_checker.sv
      - hdl/cpu_checker.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/cpu_checker_tb.sv

// ==== cpu_checker.f ====
+incdir+include
hdl/char_pkg.sv
hdl/record_pkg.sv
hdl/char_classifier.sv
hdl/record_parser.sv
hdl/record_checker.sv
hdl/cpu_checker.sv
verification/cpu_checker_tb.sv

// ==== hdl/char_classifier.sv ====
`timescale 1ns/1ps

module char_classifier (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           char,
  output char_pkg::char_info_t char_info
);

  import char_pkg::*;

  char_info_t info_next;

  always_comb
  begin
    info_next.cls    = OTHER;
    info_next.nibble = 4'd0;
    if (char >= "0" && char <= "9")
    begin
      info_next.cls    = DEC_DIGIT;
      info_next.nibble = char[3:0];
    end
    else if (char >= "a" && char <= "f")
    begin
      // 'a' is 0x61, low nibble 1 maps to 10
      info_next.cls    = HEX_LETTER;
      info_next.nibble = char[3:0] + 4'd9;
    end
    else
    begin
      case (char)
        "^":     info_next.cls = CARET;
        "@":     info_next.cls = AT;
        ":":     info_next.cls = COLON;
        "$":     info_next.cls = DOLLAR;
        "*":     info_next.cls = STAR;
        " ":     info_next.cls = SPACE;
        "<":     info_next.cls = LESS;
        "=":     info_next.cls = EQUAL;
        "#":     info_next.cls = HASH;
        default: info_next.cls = OTHER;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      char_info.cls    <= OTHER;
      char_info.nibble <= 4'd0;
    end
    else
    begin
      char_info <= info_next;
    end
  end

endmodule

// ==== hdl/char_pkg.sv ====
package char_pkg;

  // meaning of one trace character to the parser
  typedef enum logic [3:0] {
    DEC_DIGIT,
    HEX_LETTER,
    CARET,
    AT,
    COLON,
    DOLLAR,
    STAR,
    SPACE,
    LESS,
    EQUAL,
    HASH,
    OTHER
  } char_class_e;

  // nibble holds the digit value for DEC_DIGIT and HEX_LETTER only
  typedef struct packed {
    char_class_e cls;
    logic [3:0]  nibble;
  } char_info_t;

endpackage

// ==== hdl/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] freq,
  input  logic [7:0]  char,
  output logic [1:0]  format_type,
  output logic [3:0]  error_code
);

  import char_pkg::*;
  import record_pkg::*;

  char_info_t char_info;
  record_t    record;
  logic       record_done;

  // classify, parse, check, one clock each
  char_classifier u_classifier (
    .clk       (clk),
    .reset     (reset),
    .char      (char),
    .char_info (char_info)
  );

  record_parser u_parser (
    .clk         (clk),
    .reset       (reset),
    .char_info   (char_info),
    .record      (record),
    .record_done (record_done)
  );

  record_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .freq        (freq),
    .record      (record),
    .record_done (record_done),
    .format_type (format_type),
    .error_code  (error_code)
  );

endmodule

// ==== hdl/record_checker.sv ====
`timescale 1ns/1ps

`include "cpu_checker_defs.svh"

module record_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic [15:0]         freq,
  input  record_pkg::record_t record,
  input  logic                record_done,
  output logic [1:0]          format_type,
  output logic [3:0]          error_code
);

  import record_pkg::*;

  logic [15:0] half_freq;
  logic [15:0] time_rem;
  logic        time_err;
  logic        pc_err;
  logic        addr_err;
  logic        grf_err;

  // freq of 0 or 1 gives a zero half period, which disables the check
  assign half_freq = freq >> 1;
  assign time_rem  = (half_freq == 16'd0) ? 16'd0 : 16'(record.time_val) % half_freq;
  assign time_err  = time_rem != 16'd0;

  assign pc_err = record.pc[1:0] != 2'b00 ||
                  record.pc < `CC_PC_LO ||
                  record.pc > `CC_PC_HI;

  // the target word is read by kind
  assign addr_err = record.kind == MEM_WRITE &&
                    (record.target.mem_addr[1:0] != 2'b00 ||
                     record.target.mem_addr < `CC_ADDR_LO ||
                     record.target.mem_addr > `CC_ADDR_HI);

  assign grf_err = record.kind == REG_WRITE &&
                   record.target.reg_view.grf > `CC_TIME_W'(`CC_GRF_MAX);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      format_type <= 2'b00;
      error_code  <= 4'b0000;
    end
    else
    begin
      // one-cycle pulse per record, error code holds
      format_type <= 2'b00;
      if (record_done)
      begin
        format_type <= (record.kind == REG_WRITE) ? 2'b01 : 2'b10;
        error_code  <= {grf_err, addr_err, pc_err, time_err};
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) format_type != 2'b11)
    else $error("format_type reached reserved value 11");

endmodule

// ==== hdl/record_parser.sv ====
`timescale 1ns/1ps

`include "cpu_checker_defs.svh"

module record_parser (
  input  logic                 clk,
  input  logic                 reset,
  input  char_pkg::char_info_t char_info,
  output record_pkg::record_t  record,
  output logic                 record_done
);

  import char_pkg::*;
  import record_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_TIME,
    S_PC,
    S_GAP,
    S_TARGET,
    S_TGT_SPACE,
    S_LESS,
    S_EQUAL,
    S_DATA
  } state_e;

  state_e                state;
  logic [3:0]            digit_cnt;
  logic [3:0]            cnt_inc;
  record_t               rec_q;
  logic                  is_dec;
  logic                  is_hex;
  logic                  dec_ok;
  logic                  hex_full;
  logic                  tgt_digit;
  logic                  tgt_full;
  logic                  tgt_ok;
  logic [`CC_TIME_W-1:0] time_next;
  logic [`CC_TIME_W-1:0] grf_next;

  assign is_dec   = char_info.cls == DEC_DIGIT;
  assign is_hex   = is_dec || char_info.cls == HEX_LETTER;
  assign cnt_inc  = digit_cnt + 4'd1;
  assign dec_ok   = digit_cnt != 4'd0 && digit_cnt <= 4'(`CC_DEC_DIGITS_MAX);
  assign hex_full = digit_cnt == 4'(`CC_HEX_DIGITS);

  // register numbers are decimal, addresses are hex
  assign tgt_digit = (rec_q.kind == REG_WRITE) ? is_dec : is_hex;
  assign tgt_full  = (rec_q.kind == REG_WRITE) ?
                     digit_cnt == 4'(`CC_DEC_DIGITS_MAX) : hex_full;
  assign tgt_ok    = (rec_q.kind == REG_WRITE) ? dec_ok : hex_full;

  // multiply by ten and add
  assign time_next = rec_q.time_val * `CC_TIME_W'(10) + `CC_TIME_W'(char_info.nibble);
  assign grf_next  = rec_q.target.reg_view.grf * `CC_TIME_W'(10) +
                     `CC_TIME_W'(char_info.nibble);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= S_IDLE;
      digit_cnt   <= 4'd0;
      record_done <= 1'b0;
    end
    else
    begin
      record_done <= 1'b0;
      // a caret always opens a new line
      if (char_info.cls == CARET)
      begin
        state     <= S_TIME;
        digit_cnt <= 4'd0;
      end
      else
      begin
        // anything unexpected drops back to idle
        state     <= S_IDLE;
        digit_cnt <= 4'd0;
        case (state)
          S_TIME:
          begin
            if (is_dec && digit_cnt != 4'(`CC_DEC_DIGITS_MAX))
            begin
              state     <= S_TIME;
              digit_cnt <= cnt_inc;
            end
            else if (char_info.cls == AT && dec_ok)
              state <= S_PC;
          end
          S_PC:
          begin
            if (is_hex && !hex_full)
            begin
              state     <= S_PC;
              digit_cnt <= cnt_inc;
            end
            else if (char_info.cls == COLON && hex_full)
              state <= S_GAP;
          end
          S_GAP:
          begin
            if (char_info.cls == SPACE)
              state <= S_GAP;
            else if (char_info.cls == DOLLAR || char_info.cls == STAR)
              state <= S_TARGET;
          end
          S_TARGET:
          begin
            if (tgt_digit && !tgt_full)
            begin
              state     <= S_TARGET;
              digit_cnt <= cnt_inc;
            end
            else if (char_info.cls == SPACE && tgt_ok)
              state <= S_TGT_SPACE;
            else if (char_info.cls == LESS && tgt_ok)
              state <= S_LESS;
          end
          S_TGT_SPACE:
          begin
            if (char_info.cls == SPACE)
              state <= S_TGT_SPACE;
            else if (char_info.cls == LESS)
              state <= S_LESS;
          end
          S_LESS:
          begin
            if (char_info.cls == EQUAL)
              state <= S_EQUAL;
          end
          S_EQUAL:
          begin
            if (char_info.cls == SPACE)
              state <= S_EQUAL;
            else if (is_hex)
            begin
              state     <= S_DATA;
              digit_cnt <= 4'd1;
            end
          end
          S_DATA:
          begin
            if (is_hex && !hex_full)
            begin
              state     <= S_DATA;
              digit_cnt <= cnt_inc;
            end
            else if (char_info.cls == HASH && hex_full)
              record_done <= 1'b1;
          end
          default:
          begin
            state <= S_IDLE;
          end
        endcase
      end
    end
  end

  // field registers, every field is fully rewritten by a good line
  always_ff @(posedge clk)
  begin
    if (char_info.cls == CARET)
      rec_q.time_val <= '0;
    else
    begin
      case (state)
        S_TIME:
          if (is_dec)
            rec_q.time_val <= time_next;
        S_PC:
          if (is_hex)
            rec_q.pc <= {rec_q.pc[27:0], char_info.nibble};
        S_GAP:
        begin
          if (char_info.cls == DOLLAR)
          begin
            rec_q.kind            <= REG_WRITE;
            rec_q.target.mem_addr <= '0;
          end
          else if (char_info.cls == STAR)
          begin
            rec_q.kind            <= MEM_WRITE;
            rec_q.target.mem_addr <= '0;
          end
        end
        S_TARGET:
        begin
          if (rec_q.kind == REG_WRITE && is_dec)
            rec_q.target.reg_view.grf <= grf_next;
          else if (rec_q.kind == MEM_WRITE && is_hex)
            rec_q.target.mem_addr <= {rec_q.target.mem_addr[27:0], char_info.nibble};
        end
        S_EQUAL, S_DATA:
          if (is_hex)
            rec_q.data <= {rec_q.data[27:0], char_info.nibble};
        default:
        begin
        end
      endcase
    end
  end

  assign record = rec_q;

  // a record needs at least a '#' and a new '^' between two strobes
  assert property (@(posedge clk) disable iff (reset) record_done |=> !record_done)
    else $error("record_done high in two consecutive cycles");

  assert property (@(posedge clk) disable iff (reset) digit_cnt <= 4'(`CC_HEX_DIGITS))
    else $error("digit counter beyond hex field width");

endmodule

// ==== hdl/record_pkg.sv ====
`include "cpu_checker_defs.svh"

package record_pkg;

  typedef enum logic {
    REG_WRITE,
    MEM_WRITE
  } record_kind_e;

  // register number sits in the low bits of the target word
  typedef struct packed {
    logic [31-`CC_TIME_W:0] pad;
    logic [`CC_TIME_W-1:0]  grf;
  } reg_view_t;

  // one target word, address for memory writes, register for register writes
  typedef union packed {
    logic [31:0] mem_addr;
    reg_view_t   reg_view;
  } target_u;

  // one parsed trace line
  typedef struct packed {
    record_kind_e          kind;
    logic [`CC_TIME_W-1:0] time_val;
    logic [31:0]           pc;
    target_u               target;
    logic [31:0]           data;
  } record_t;

endpackage

// ==== include/cpu_checker_defs.svh ====
`ifndef CPU_CHECKER_DEFS_SVH
`define CPU_CHECKER_DEFS_SVH

// digit limits of the trace line fields
`define CC_DEC_DIGITS_MAX 4
`define CC_HEX_DIGITS 8

// time and register numbers fit 9999
`define CC_TIME_W 14

// legal instruction window, inclusive
`define CC_PC_LO 32'h0000_3000
`define CC_PC_HI 32'h0000_4fff

// legal data memory window, inclusive
`define CC_ADDR_LO 32'h0000_0000
`define CC_ADDR_HI 32'h0000_2fff

// highest general register
`define CC_GRF_MAX 31

`endif

// ==== verification/cpu_checker_tb.sv ====
`timescale 1ns/1ps

`include "cpu_checker_defs.svh"

module cpu_checker_tb;

  logic        clk;
  logic        reset;
  logic [15:0] freq;
  logic [7:0]  char;
  logic [1:0]  format_type;
  logic [3:0]  error_code;

  int         errors;
  int         checks;
  int         chars_sent;
  logic [3:0] held_err;
  // expected {format_type, error_code} for each driven character
  logic [5:0] expect_q[$];

  cpu_checker dut (
    .clk         (clk),
    .reset       (reset),
    .freq        (freq),
    .char        (char),
    .format_type (format_type),
    .error_code  (error_code)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED at %0d ns: %s expected 0x%0h, observed 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // reference error code from the field rules and the windows
  function automatic logic [3:0] expected_error(input bit is_mem, input int t_val,
                                                input logic [31:0] pc,
                                                input logic [31:0] target,
                                                input logic [15:0] f);
    int         half;
    logic [3:0] err;
    half   = f / 2;
    err    = 4'b0000;
    err[0] = half != 0 && (t_val % half) != 0;
    err[1] = pc % 4 != 0 || pc < `CC_PC_LO || pc > `CC_PC_HI;
    if (is_mem)
      err[2] = target % 4 != 0 || target > `CC_ADDR_HI;
    else
      err[3] = target > `CC_GRF_MAX;
    return err;
  endfunction

  // outputs are checked on the falling edge, before the next character goes out
  task automatic send_char(input logic [7:0] c, input logic [1:0] fmt,
                           input logic [3:0] err);
    logic [5:0] due;
    @(negedge clk);
    if (expect_q.size() == 3)
    begin
      due = expect_q.pop_front();
      check_value("format_type", due[5:4], format_type);
      check_value("error_code", due[3:0], error_code);
    end
    char = c;
    chars_sent++;
    if (fmt != 2'b00)
      held_err = err;
    expect_q.push_back({fmt, held_err});
  endtask

  // the expected pulse belongs to the last character of the line
  task automatic send_line(input string s, input logic [1:0] fmt, input logic [3:0] err);
    int i;
    for (i = 0; i < s.len(); i++)
      send_char(s[i], (i == s.len() - 1) ? fmt : 2'b00, err);
  endtask

  task automatic send_idle(input int n);
    repeat (n) send_char(" ", 2'b00, 4'b0000);
  endtask

  // freq is read by the checker two clocks after '#', so let the pipe drain first
  task automatic apply_freq(input logic [15:0] f);
    send_idle(3);
    freq = f;
  endtask

  task automatic send_reg(input int t_val, input logic [31:0] pc, input int grf,
                          input logic [31:0] data, input bit spaced);
    string sp;
    string line;
    if (spaced)
      sp = " ";
    else
      sp = "";
    line = $sformatf("^%0d@%08x:%s$%0d%s<=%s%08x#", t_val, pc, sp, grf, sp, sp, data);
    send_line(line, 2'b01, expected_error(1'b0, t_val, pc, grf, freq));
  endtask

  task automatic send_mem(input int t_val, input logic [31:0] pc, input logic [31:0] addr,
                          input logic [31:0] data, input bit spaced);
    string sp;
    string line;
    if (spaced)
      sp = " ";
    else
      sp = "";
    line = $sformatf("^%0d@%08x:%s*%08x%s<=%s%08x#", t_val, pc, sp, addr, sp, sp, data);
    send_line(line, 2'b10, expected_error(1'b1, t_val, pc, addr, freq));
  endtask

  task automatic test_legal_lines();
    apply_freq(16'd10);
    send_reg(25, 32'h3000, 5, 32'hdeadbeef, 1'b0);
    send_reg(25, 32'h4ffc, 31, 32'h0000_0001, 1'b1);
    send_mem(100, 32'h3004, 32'h2ffc, 32'h1234_5678, 1'b0);
    send_mem(0, 32'h4000, 32'h0000, 32'hcafe_f00d, 1'b1);
    send_idle(2);
  endtask

  // error_code must keep the bit 3 result across every bad line
  task automatic test_malformed_lines();
    send_reg(10, 32'h3000, 40, 32'h0000_0001, 1'b1);
    send_line("^12345@00003000: $1 <= 00000001#", 2'b00, 4'b0000);
    send_line("^10@0003000: $1 <= 00000001#", 2'b00, 4'b0000);
    send_line("^10@00003000 $1 <= 00000001#", 2'b00, 4'b0000);
    send_line("^10@0000300C: $1 <= 00000001#", 2'b00, 4'b0000);
    send_line("^10@00003000: $1 <= 0000 0001#", 2'b00, 4'b0000);
    send_line("^10@00003000: $1 < = 00000001#", 2'b00, 4'b0000);
    send_idle(4);
  endtask

  task automatic test_error_bits();
    apply_freq(16'd4);
    send_reg(5, 32'h3000, 1, 32'h0000_0010, 1'b1);
    send_reg(6, 32'h3000, 1, 32'h0000_0010, 1'b1);
    send_reg(6, 32'h3002, 1, 32'h0000_0010, 1'b0);
    send_reg(6, 32'h3004, 1, 32'h0000_0010, 1'b0);
    send_mem(6, 32'h3000, 32'h3000, 32'h0000_0020, 1'b1);
    send_mem(6, 32'h3000, 32'h2000, 32'h0000_0020, 1'b1);
    send_reg(6, 32'h3000, 32, 32'h0000_0030, 1'b0);
    send_reg(6, 32'h3000, 0, 32'h0000_0030, 1'b0);
    send_idle(2);
  endtask

  // partial lines cut short by a new caret
  task automatic test_restart();
    send_line("^12@00003000: *00", 2'b00, 4'b0000);
    send_mem(8, 32'h3008, 32'h0100, 32'h0bad_cafe, 1'b1);
    send_line("^1", 2'b00, 4'b0000);
    send_reg(12, 32'h300c, 7, 32'h0000_0007, 1'b0);
    send_idle(2);
  endtask

  task automatic test_back_to_back();
    send_reg(4, 32'h3000, 2, 32'h0000_0002, 1'b0);
    send_mem(4, 32'h3002, 32'h0004, 32'h0000_0003, 1'b0);
    send_reg(7, 32'h3008, 33, 32'h0000_0004, 1'b1);
    send_mem(8, 32'h300c, 32'h2ffc, 32'h0000_0005, 1'b0);
  endtask

  task automatic test_random_lines();
    int n;
    for (n = 0; n < 40; n++)
    begin
      apply_freq(16'($urandom_range(20, 0)));
      if ($urandom_range(1, 0) == 1)
        send_mem($urandom_range(9999, 0), $urandom_range(32'h5100, 32'h2f00),
                 $urandom_range(32'h3100, 0), $urandom, 1'($urandom_range(1, 0)));
      else
        send_reg($urandom_range(9999, 0), $urandom_range(32'h5100, 32'h2f00),
                 $urandom_range(40, 0), $urandom, 1'($urandom_range(1, 0)));
    end
  endtask

  // run limit grows with the characters sent
  initial
  begin
    while ($time <= 64'(chars_sent) * 40 + 2000)
      #100;
    $display("ERROR: run timed out after %0d characters", chars_sent);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    void'($urandom(72));
    reset      = 1'b1;
    freq       = 16'd0;
    char       = " ";
    errors     = 0;
    checks     = 0;
    chars_sent = 0;
    held_err   = 4'b0000;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    check_value("format_type", 2'b00, format_type);
    check_value("error_code", 4'b0000, error_code);

    test_legal_lines();
    test_malformed_lines();
    test_error_bits();
    test_restart();
    test_back_to_back();
    test_random_lines();
    send_idle(4);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
